/* Makefile */
SRC = design/rv_core_config.svh \
      design/rv_core_pkg.sv \
      design/hazard_unit.sv \
      design/instr_decoder.sv \
      design/reg_file.sv \
      design/data_mem.sv \
      design/rv_pipeline_core.sv \
      sim/tb_rv_core.sv

obj_dir/Vtb_rv_core: compile.f $(SRC)
	verilator --binary --assert -j 0 --top-module tb_rv_core -f compile.f

run: obj_dir/Vtb_rv_core
	./obj_dir/Vtb_rv_core

clean:
	rm -rf obj_dir

.PHONY: run clean

/* compile.f */
+incdir+design
design/rv_core_pkg.sv
design/hazard_unit.sv
design/instr_decoder.sv
design/reg_file.sv
design/data_mem.sv
design/rv_pipeline_core.sv
sim/tb_rv_core.sv

/* design/data_mem.sv */
`include "rv_core_config.svh"

module data_mem (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               rd_en_i,
    input  logic               wr_en_i,
    input  rv_core_pkg::word_t addr_i,
    input  rv_core_pkg::word_t wr_data_i,
    output rv_core_pkg::word_t rd_data_o
);

    localparam int IDX_W = $clog2(`RV_DMEM_WORDS);

    rv_core_pkg::word_t mem_q [`RV_DMEM_WORDS];
    logic [IDX_W-1:0]   word_idx;

    // Word address, upper bits wrap around the memory
    assign word_idx = addr_i[IDX_W+1:2];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            mem_q[word_idx] <= wr_data_i;
        end
    end

    // Read data only matters for loads
    assign rd_data_o = rd_en_i ? mem_q[word_idx] : '0;

    // An instruction is a load or a store, never both
    a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(rd_en_i && wr_en_i));

endmodule

/* design/hazard_unit.sv */
module hazard_unit (
    // Decode-stage sources, for the load-use check
    input  rv_core_pkg::reg_addr_t rd_addr1_d_i,
    input  rv_core_pkg::reg_addr_t rd_addr2_d_i,
    // Execute-stage sources and destination
    input  rv_core_pkg::reg_addr_t rd_addr1_e_i,
    input  rv_core_pkg::reg_addr_t rd_addr2_e_i,
    input  rv_core_pkg::reg_addr_t wr_addr_e_i,
    input  logic                   mem_rd_en_e_i,
    // Older producers
    input  rv_core_pkg::reg_addr_t wr_addr_m_i,
    input  rv_core_pkg::reg_addr_t wr_addr_w_i,
    input  logic                   reg_wr_en_m_i,
    input  logic                   reg_wr_en_w_i,
    // Taken branch from execute
    input  logic                   pc_src_i,

    output rv_core_pkg::fwd_sel_e  forward_a_e_o,
    output rv_core_pkg::fwd_sel_e  forward_b_e_o,
    output logic                   stall_o,
    output logic                   flush_o
);

    // Live producers, x0 is never a real destination
    logic mem_writes;
    logic wb_writes;
    logic load_in_ex;

    assign mem_writes = reg_wr_en_m_i && (wr_addr_m_i != '0);
    assign wb_writes  = reg_wr_en_w_i && (wr_addr_w_i != '0);
    assign load_in_ex = mem_rd_en_e_i && (wr_addr_e_i != '0);

    always_comb begin
        // Memory stage is younger so it wins over writeback
        if (mem_writes && (wr_addr_m_i == rd_addr1_e_i)) begin
            forward_a_e_o = rv_core_pkg::FWD_MEM;
        end else if (wb_writes && (wr_addr_w_i == rd_addr1_e_i)) begin
            forward_a_e_o = rv_core_pkg::FWD_WB;
        end else begin
            forward_a_e_o = rv_core_pkg::FWD_NONE;
        end

        // Same priority for the second operand
        if (mem_writes && (wr_addr_m_i == rd_addr2_e_i)) begin
            forward_b_e_o = rv_core_pkg::FWD_MEM;
        end else if (wb_writes && (wr_addr_w_i == rd_addr2_e_i)) begin
            forward_b_e_o = rv_core_pkg::FWD_WB;
        end else begin
            forward_b_e_o = rv_core_pkg::FWD_NONE;
        end
    end

    // Load data only exists after memory, so the reader waits one cycle
    assign stall_o = load_in_ex &&
                     ((wr_addr_e_i == rd_addr1_d_i) || (wr_addr_e_i == rd_addr2_d_i));

    // Taken branch kills the two younger instructions
    assign flush_o = pc_src_i;

endmodule

/* design/instr_decoder.sv */
module instr_decoder (
    input  rv_core_pkg::instr_t instr_i,
    output rv_core_pkg::ctrl_t  ctrl_o
);

    // Major opcodes of the subset
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        // Anything not matched below stays a bubble
        ctrl_o = '0;
        unique case (opcode)
            OP_R: begin
                ctrl_o.rd  = instr_i[11:7];
                ctrl_o.rs1 = instr_i[19:15];
                ctrl_o.rs2 = instr_i[24:20];
                ctrl_o.reg_wr_en = 1'b1;
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    ctrl_o.alu_op = rv_core_pkg::ALU_ADD;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    ctrl_o.alu_op = rv_core_pkg::ALU_SUB;
                end else if (funct3 == 3'b111 && funct7 == 7'b0000000) begin
                    ctrl_o.alu_op = rv_core_pkg::ALU_AND;
                end else if (funct3 == 3'b110 && funct7 == 7'b0000000) begin
                    ctrl_o.alu_op = rv_core_pkg::ALU_OR;
                end else begin
                    ctrl_o = '0;
                end
            end
            OP_I, OP_LOAD: begin
                // ADDI and LW share the I immediate and an adder
                ctrl_o.rd        = instr_i[11:7];
                ctrl_o.rs1       = instr_i[19:15];
                ctrl_o.imm       = {{20{instr_i[31]}}, instr_i[31:20]};
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.mem_rd_en = (opcode == OP_LOAD);
                if (funct3 != ((opcode == OP_LOAD) ? 3'b010 : 3'b000)) begin
                    ctrl_o = '0;
                end
            end
            OP_STORE: begin
                ctrl_o.rs1       = instr_i[19:15];
                ctrl_o.rs2       = instr_i[24:20];
                ctrl_o.imm       = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.mem_wr_en = (funct3 == 3'b010);
            end
            OP_BRANCH: begin
                // Only BEQ, compared in execute
                ctrl_o.rs1    = instr_i[19:15];
                ctrl_o.rs2    = instr_i[24:20];
                ctrl_o.imm    = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                 instr_i[30:25], instr_i[11:8], 1'b0};
                ctrl_o.branch = (funct3 == 3'b000);
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

/* design/reg_file.sv */
module reg_file (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  rv_core_pkg::reg_addr_t rs1_i,
    input  rv_core_pkg::reg_addr_t rs2_i,
    input  rv_core_pkg::reg_addr_t rd_i,
    input  logic                   wr_en_i,
    input  rv_core_pkg::word_t     wr_data_i,
    output rv_core_pkg::word_t     rs1_data_o,
    output rv_core_pkg::word_t     rs2_data_o
);

    rv_core_pkg::word_t regs_q [32];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (rd_i != '0)) begin
            regs_q[rd_i] <= wr_data_i;
        end
    end

    // Writeback and decode share a cycle, so the new value passes straight through
    always_comb begin
        if (rs1_i == '0) begin
            rs1_data_o = '0;
        end else if (wr_en_i && (rs1_i == rd_i)) begin
            rs1_data_o = wr_data_i;
        end else begin
            rs1_data_o = regs_q[rs1_i];
        end
        if (rs2_i == '0) begin
            rs2_data_o = '0;
        end else if (wr_en_i && (rs2_i == rd_i)) begin
            rs2_data_o = wr_data_i;
        end else begin
            rs2_data_o = regs_q[rs2_i];
        end
    end

    // Writeback must already drop writes aimed at x0
    a_no_x0_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wr_en_i |-> (rd_i != '0));

endmodule

/* design/rv_core_config.svh */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data memory depth in 32-bit words
// Must stay a power of two, the address is wrapped by bit slicing
`define RV_DMEM_WORDS 64

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* design/rv_core_pkg.sv */
package rv_core_pkg;

    // Data word, also used for addresses and the PC
    typedef logic [31:0] word_t;

    // Architectural register index
    typedef logic [4:0] reg_addr_t;

    // Raw instruction word
    typedef logic [31:0] instr_t;

    // ALU functions needed by the subset
    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01,
        ALU_AND = 2'b10,
        ALU_OR  = 2'b11
    } alu_op_e;

    // Execute-stage operand source
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00, // value read in decode
        FWD_WB   = 2'b01, // result in writeback
        FWD_MEM  = 2'b10  // ALU result in memory stage
    } fwd_sel_e;

    // Decoded controls, all zero is a bubble
    typedef struct packed {
        logic      reg_wr_en;
        logic      mem_rd_en;
        logic      mem_wr_en;
        logic      branch;
        logic      use_imm;
        alu_op_e   alu_op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
    } ctrl_t;

    // Decode to execute
    typedef struct packed {
        ctrl_t ctrl;
        word_t pc;
        word_t rs1_data;
        word_t rs2_data;
    } id_ex_t;

    // Execute to memory
    typedef struct packed {
        logic      reg_wr_en;
        logic      mem_rd_en;
        logic      mem_wr_en;
        reg_addr_t rd;
        word_t     alu_result;
        word_t     store_data;
    } ex_mem_t;

    // Memory to writeback
    typedef struct packed {
        logic      reg_wr_en;
        reg_addr_t rd;
        word_t     result;
    } mem_wb_t;

endpackage

/* design/rv_pipeline_core.sv */
`include "rv_core_config.svh"

module rv_pipeline_core (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    output rv_core_pkg::word_t     imem_addr_o,
    input  rv_core_pkg::instr_t    imem_data_i,
    output logic                   wb_valid_o,
    output rv_core_pkg::reg_addr_t wb_addr_o,
    output rv_core_pkg::word_t     wb_data_o
);

    // ADDI x0, x0, 0
    localparam rv_core_pkg::instr_t NOP_INSTR = 32'h0000_0013;

    // Fetch
    rv_core_pkg::word_t    pc_q;
    rv_core_pkg::word_t    if_id_pc_q;
    rv_core_pkg::instr_t   if_id_instr_q;

    // Decode
    rv_core_pkg::ctrl_t    ctrl_d;
    rv_core_pkg::word_t    rs1_data_d;
    rv_core_pkg::word_t    rs2_data_d;

    // Pipeline registers
    rv_core_pkg::id_ex_t   id_ex_q;
    rv_core_pkg::ex_mem_t  ex_mem_q;
    rv_core_pkg::mem_wb_t  mem_wb_q;

    // Hazard control
    rv_core_pkg::fwd_sel_e fwd_a;
    rv_core_pkg::fwd_sel_e fwd_b;
    logic                  stall;
    logic                  flush;

    // Execute
    rv_core_pkg::word_t    src_a_e;
    rv_core_pkg::word_t    src_b_e;
    rv_core_pkg::word_t    alu_b_e;
    rv_core_pkg::word_t    alu_result_e;
    rv_core_pkg::word_t    branch_target_e;
    logic                  branch_taken_e;

    // Memory and writeback
    rv_core_pkg::word_t    mem_rd_data_m;
    rv_core_pkg::word_t    result_m;
    logic                  wb_we_w;

    assign imem_addr_o = pc_q;

    // Branch target wins over the stall hold
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q          <= `RV_RESET_PC;
            if_id_pc_q    <= '0;
            if_id_instr_q <= NOP_INSTR;
        end else if (flush) begin
            pc_q          <= branch_target_e;
            if_id_pc_q    <= '0;
            if_id_instr_q <= NOP_INSTR;
        end else if (!stall) begin
            pc_q          <= pc_q + 32'd4;
            if_id_pc_q    <= pc_q;
            if_id_instr_q <= imem_data_i;
        end
    end

    instr_decoder u_decoder (
        .instr_i (if_id_instr_q),
        .ctrl_o  (ctrl_d)
    );

    // Written from writeback, read in decode
    reg_file u_reg_file (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs1_i      (ctrl_d.rs1),
        .rs2_i      (ctrl_d.rs2),
        .rd_i       (mem_wb_q.rd),
        .wr_en_i    (wb_we_w),
        .wr_data_i  (mem_wb_q.result),
        .rs1_data_o (rs1_data_d),
        .rs2_data_o (rs2_data_d)
    );

    hazard_unit u_hazard (
        .rd_addr1_d_i  (ctrl_d.rs1),
        .rd_addr2_d_i  (ctrl_d.rs2),
        .rd_addr1_e_i  (id_ex_q.ctrl.rs1),
        .rd_addr2_e_i  (id_ex_q.ctrl.rs2),
        .wr_addr_e_i   (id_ex_q.ctrl.rd),
        .mem_rd_en_e_i (id_ex_q.ctrl.mem_rd_en),
        .wr_addr_m_i   (ex_mem_q.rd),
        .wr_addr_w_i   (mem_wb_q.rd),
        .reg_wr_en_m_i (ex_mem_q.reg_wr_en),
        .reg_wr_en_w_i (mem_wb_q.reg_wr_en),
        .pc_src_i      (branch_taken_e),
        .forward_a_e_o (fwd_a),
        .forward_b_e_o (fwd_b),
        .stall_o       (stall),
        .flush_o       (flush)
    );

    // Stall and flush both push a bubble into execute
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_q <= '0;
        end else if (flush || stall) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= '{ctrl: ctrl_d, pc: if_id_pc_q, rs1_data: rs1_data_d,
                         rs2_data: rs2_data_d};
        end
    end

    // Operand muxes
    always_comb begin
        unique case (fwd_a)
            rv_core_pkg::FWD_MEM: src_a_e = ex_mem_q.alu_result;
            rv_core_pkg::FWD_WB:  src_a_e = mem_wb_q.result;
            default:              src_a_e = id_ex_q.rs1_data;
        endcase
        unique case (fwd_b)
            rv_core_pkg::FWD_MEM: src_b_e = ex_mem_q.alu_result;
            rv_core_pkg::FWD_WB:  src_b_e = mem_wb_q.result;
            default:              src_b_e = id_ex_q.rs2_data;
        endcase
    end

    assign alu_b_e = id_ex_q.ctrl.use_imm ? id_ex_q.ctrl.imm : src_b_e;

    always_comb begin
        unique case (id_ex_q.ctrl.alu_op)
            rv_core_pkg::ALU_SUB: alu_result_e = src_a_e - alu_b_e;
            rv_core_pkg::ALU_AND: alu_result_e = src_a_e & alu_b_e;
            rv_core_pkg::ALU_OR:  alu_result_e = src_a_e | alu_b_e;
            default:              alu_result_e = src_a_e + alu_b_e;
        endcase
    end

    // BEQ resolves here, on forwarded operands
    assign branch_taken_e  = id_ex_q.ctrl.branch && (src_a_e == src_b_e);
    assign branch_target_e = id_ex_q.pc + id_ex_q.ctrl.imm;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.reg_wr_en  <= id_ex_q.ctrl.reg_wr_en;
            ex_mem_q.mem_rd_en  <= id_ex_q.ctrl.mem_rd_en;
            ex_mem_q.mem_wr_en  <= id_ex_q.ctrl.mem_wr_en;
            ex_mem_q.rd         <= id_ex_q.ctrl.rd;
            ex_mem_q.alu_result <= alu_result_e;
            ex_mem_q.store_data <= src_b_e;
        end
    end

    data_mem u_dmem (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .rd_en_i   (ex_mem_q.mem_rd_en),
        .wr_en_i   (ex_mem_q.mem_wr_en),
        .addr_i    (ex_mem_q.alu_result),
        .wr_data_i (ex_mem_q.store_data),
        .rd_data_o (mem_rd_data_m)
    );

    assign result_m = ex_mem_q.mem_rd_en ? mem_rd_data_m : ex_mem_q.alu_result;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.reg_wr_en <= ex_mem_q.reg_wr_en;
            mem_wb_q.rd        <= ex_mem_q.rd;
            mem_wb_q.result    <= result_m;
        end
    end

    // x0 writes retire silently
    assign wb_we_w    = mem_wb_q.reg_wr_en && (mem_wb_q.rd != '0);
    assign wb_valid_o = wb_we_w;
    assign wb_addr_o  = mem_wb_q.rd;
    assign wb_data_o  = mem_wb_q.result;

    // A load and a branch never share execute, so no stall meets a flush
    a_stall_flush_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(stall && flush));

endmodule

/* sim/tb_rv_core.sv */
`include "rv_core_config.svh"

module tb_rv_core;

    localparam rv_core_pkg::instr_t NOP = 32'h0000_0013;
    localparam int PROG_MAX = 1024;
    localparam int DW = $clog2(`RV_DMEM_WORDS);

    logic                   clk;
    logic                   arst_n;
    rv_core_pkg::word_t     imem_addr;
    rv_core_pkg::instr_t    imem_data;
    logic                   wb_valid;
    rv_core_pkg::reg_addr_t wb_addr;
    rv_core_pkg::word_t     wb_data;

    // Program image and the test sections inside it
    rv_core_pkg::instr_t    prog [PROG_MAX];
    int                     prog_len = 0;
    logic                   prog_ready = 1'b0;
    int                     sec_start [$];
    string                  sec_name [$];
    logic [31:0]            rng_state = 32'h47f1;

    // Expected retiring writes, in program order
    rv_core_pkg::reg_addr_t exp_addr_q [$];
    rv_core_pkg::word_t     exp_data_q [$];
    rv_core_pkg::word_t     exp_pc_q [$];

    rv_pipeline_core dut (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .wb_valid_o  (wb_valid),
        .wb_addr_o   (wb_addr),
        .wb_data_o   (wb_data)
    );

    always #4 clk = ~clk;

    // Combinational instruction memory, NOP outside the program
    always_comb begin
        if (imem_addr[1:0] == 2'b00 && imem_addr < (prog_len << 2)) begin
            imem_data = prog[imem_addr[11:2]];
        end else begin
            imem_data = NOP;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int random_below(input int n);
        rng_state = xorshift(rng_state);
        return int'(rng_state % n);
    endfunction

    // Encoders, op 0..3 picks ADD SUB AND OR
    function automatic rv_core_pkg::instr_t alu_rr(input int op, input int rd, input int rs1,
                                                   input int rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = (op == 1) ? 7'b0100000 : 7'b0000000;
        f3 = (op == 2) ? 3'b111 : (op == 3) ? 3'b110 : 3'b000;
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic rv_core_pkg::instr_t addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic rv_core_pkg::instr_t lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic rv_core_pkg::instr_t sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // Byte offset, always a positive multiple of 4 here
    function automatic rv_core_pkg::instr_t beq(input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic void emit(input rv_core_pkg::instr_t ins);
        prog[prog_len] = ins;
        prog_len++;
    endfunction

    function automatic void section(input string name);
        sec_start.push_back(prog_len);
        sec_name.push_back(name);
    endfunction

    function automatic string test_of(input rv_core_pkg::word_t pc);
        string name;
        name = "unknown";
        for (int i = 0; i < sec_start.size(); i++) begin
            if ((pc >> 2) >= sec_start[i]) begin
                name = sec_name[i];
            end
        end
        return name;
    endfunction

    function automatic void build_program();
        int kind;
        int rd;
        int rs1;
        int rs2;
        int last_rd;
        // Back-to-back producers, on rs1 then on rs2
        section("fwd_mem");
        emit(addi(1, 0, 5));
        emit(addi(2, 1, 3));
        emit(alu_rr(0, 3, 0, 2));
        emit(alu_rr(1, 4, 3, 1));
        emit(alu_rr(2, 5, 4, 3));
        emit(alu_rr(3, 6, 5, 4));
        // Two apart, then both stages holding x11
        section("fwd_wb");
        emit(addi(7, 0, 9));
        emit(addi(8, 0, 1));
        emit(alu_rr(0, 9, 7, 0));
        emit(alu_rr(0, 10, 0, 8));
        emit(addi(11, 0, 20));
        emit(addi(11, 0, 30));
        emit(alu_rr(0, 12, 11, 11));
        // Loads used right away, including as store data
        section("load_use");
        emit(addi(13, 0, 'h55));
        emit(sw(13, 0, 8));
        emit(lw(14, 0, 8));
        emit(alu_rr(0, 15, 14, 14));
        emit(lw(16, 0, 8));
        emit(alu_rr(1, 17, 0, 16));
        emit(lw(18, 0, 8));
        emit(sw(18, 0, 12));
        emit(lw(19, 0, 12));
        emit(addi(19, 19, 1));
        // Taken skips two, not taken skips none
        section("branch");
        emit(addi(20, 0, 4));
        emit(addi(21, 0, 4));
        emit(beq(20, 21, 12));
        emit(addi(22, 0, 1));
        emit(addi(23, 0, 2));
        emit(addi(24, 0, 3));
        emit(beq(20, 0, 8));
        emit(addi(25, 0, 5));
        emit(addi(26, 0, 6));
        emit(lw(27, 0, 8));
        emit(beq(27, 13, 8));
        emit(addi(28, 0, 7));
        emit(addi(29, 0, 8));
        // Writes to x0 must vanish
        section("x0");
        emit(addi(0, 0, 77));
        emit(alu_rr(0, 30, 0, 0));
        emit(addi(0, 1, 5));
        emit(addi(31, 0, 1));
        emit(lw(0, 0, 8));
        emit(alu_rr(0, 30, 0, 1));
        // Random mix on x0..x7, loads and stores based on x0
        section("random");
        last_rd = 0;
        for (int n = 0; n < 400; n++) begin
            kind = random_below(8);
            rd   = random_below(8);
            rs1  = random_below(8);
            rs2  = random_below(8);
            case (kind)
                0, 1:    emit(alu_rr(random_below(4), rd, rs1, rs2));
                2, 3:    emit(addi(rd, rs1, random_below(4096) - 2048));
                4:       emit(lw(rd, 0, 4 * random_below(`RV_DMEM_WORDS)));
                5:       emit(sw(rs2, 0, 4 * random_below(`RV_DMEM_WORDS)));
                6:       emit(beq(rs1, rs2, 4 * (1 + random_below(4))));
                default: emit(alu_rr(random_below(4), rd, last_rd, rs2));
            endcase
            last_rd = rd;
        end
    endfunction

    // Architectural interpreter of the subset
    function automatic void run_reference();
        rv_core_pkg::word_t     regs [32];
        rv_core_pkg::word_t     dmem [`RV_DMEM_WORDS];
        rv_core_pkg::word_t     pc;
        rv_core_pkg::word_t     next_pc;
        rv_core_pkg::word_t     res;
        rv_core_pkg::word_t     addr;
        rv_core_pkg::word_t     imm_i;
        rv_core_pkg::word_t     imm_s;
        rv_core_pkg::word_t     imm_b;
        rv_core_pkg::instr_t    ins;
        rv_core_pkg::reg_addr_t rd;
        rv_core_pkg::reg_addr_t rs1;
        rv_core_pkg::reg_addr_t rs2;
        logic [DW-1:0]          widx;
        logic                   wr;
        int                     steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
            dmem[i] = '0;
        end
        pc = `RV_RESET_PC;
        steps = 0;
        while (pc < (prog_len << 2) && steps < 100000) begin
            ins     = prog[pc[11:2]];
            rd      = ins[11:7];
            rs1     = ins[19:15];
            rs2     = ins[24:20];
            imm_i   = rv_core_pkg::word_t'($signed(ins) >>> 20);
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            next_pc = pc + 32'd4;
            wr      = 1'b0;
            res     = '0;
            case (ins[6:0])
                7'b0110011: begin
                    case ({ins[30], ins[14:12]})
                        4'b0000: res = regs[rs1] + regs[rs2];
                        4'b1000: res = regs[rs1] - regs[rs2];
                        4'b0111: res = regs[rs1] & regs[rs2];
                        default: res = regs[rs1] | regs[rs2];
                    endcase
                    wr = 1'b1;
                end
                7'b0010011: begin
                    res = regs[rs1] + imm_i;
                    wr  = 1'b1;
                end
                7'b0000011: begin
                    addr = regs[rs1] + imm_i;
                    widx = DW'((addr >> 2) % `RV_DMEM_WORDS);
                    res  = dmem[widx];
                    wr   = 1'b1;
                end
                7'b0100011: begin
                    addr = regs[rs1] + imm_s;
                    widx = DW'((addr >> 2) % `RV_DMEM_WORDS);
                    dmem[widx] = regs[rs2];
                end
                7'b1100011: begin
                    if (regs[rs1] == regs[rs2]) begin
                        next_pc = pc + imm_b;
                    end
                end
                default: begin
                end
            endcase
            if (wr && rd != 5'd0) begin
                regs[rd] = res;
                exp_addr_q.push_back(rd);
                exp_data_q.push_back(res);
                exp_pc_q.push_back(pc);
            end
            pc = next_pc;
            steps++;
        end
    endfunction

    task automatic check_equal(input string test, input string field,
                               input rv_core_pkg::word_t expected,
                               input rv_core_pkg::word_t actual);
        if (expected !== actual) begin
            $display("error: %s %s expected 0x%08h actual 0x%08h",
                     test, field, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Outputs come from mem_wb, stable at the falling edge
    always @(negedge clk) begin
        if (arst_n && wb_valid) begin
            if (exp_addr_q.size() == 0) begin
                $display("register write to x%0d reported with no write left to expect",
                         wb_addr);
                $display("Simulation failed");
                $fatal(1);
            end else begin
                check_equal(test_of(exp_pc_q[0]), "rd", {27'b0, exp_addr_q[0]},
                            {27'b0, wb_addr});
                check_equal(test_of(exp_pc_q[0]), "data", exp_data_q[0], wb_data);
                void'(exp_addr_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_pc_q.pop_front());
            end
        end
    end

    // Eight cycles per instruction covers stalls, flushes and the drain
    initial begin
        wait (prog_ready);
        repeat (8 * prog_len + 100) @(posedge clk);
        $display("watchdog expired with %0d register writes still missing", exp_addr_q.size());
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        build_program();
        run_reference();
        prog_ready = 1'b1;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        while (exp_addr_q.size() != 0) begin
            @(posedge clk);
        end
        // Idle window catches writes past the end of the program
        repeat (20) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
